// File: include/enc_stage_cfg.svh
/* Frame geometry, data widths and APB byte map of the encoder stage
   Frame sides must be powers of two and window bases aligned to window size */
`ifndef ENC_STAGE_CFG_SVH
`define ENC_STAGE_CFG_SVH

`define ENC_IMG_W 8
`define ENC_IMG_H 8
`define ENC_POOL_W 4
`define ENC_POOL_H 4

`define ENC_PIX_W 16
`define ENC_WGT_W 8
`define ENC_ACC_W 32

`define ENC_APB_AW 12
`define ENC_APB_DW 32

// Byte addresses
`define ENC_ADDR_CTRL 12'h000
`define ENC_ADDR_STATUS 12'h004
`define ENC_ADDR_KERNEL 12'h008
`define ENC_ADDR_BIAS 12'h02C
`define ENC_ADDR_IMAGE 12'h400
`define ENC_ADDR_POOL 12'h800

`endif

// File: logic/enc_stage_pkg.sv
/* Data and index types shared by the encoder stage
   Activations are unsigned, one bit narrower than a pixel */
`include "enc_stage_cfg.svh"

package enc_stage_pkg;

    // Input pixel
    typedef logic signed [`ENC_PIX_W-1:0] pix_t;

    // Kernel tap or bias
    typedef logic signed [`ENC_WGT_W-1:0] wgt_t;

    typedef logic signed [`ENC_ACC_W-1:0] acc_t;

    // ReLU output, never negative
    typedef logic [`ENC_PIX_W-2:0] act_t;

    typedef logic [$clog2(`ENC_IMG_W*`ENC_IMG_H)-1:0] img_addr_t;

    typedef logic [$clog2(`ENC_POOL_W*`ENC_POOL_H)-1:0] pool_addr_t;

endpackage

// File: logic/pixel_ram.sv
/* Simple dual-port memory, one write and one registered read per cycle
   Contents are not reset; a read of an unwritten word is undefined */
`timescale 1ns/100ps

module pixel_ram #(
    parameter type T = logic [15:0],
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  T                         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output T                         rdata
);
    T mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // Old data on a same-address collision
        rdata <= mem[raddr];
    end

    a_waddr_range: assert property (@(posedge clk) we |-> int'(waddr) < DEPTH);

endmodule

// File: logic/enc_apb_regs.sv
/* APB slave with weights, control and status of the encoder stage
   Pool window reads take one wait state; rejected writes have no effect */
`timescale 1ns/100ps
`include "enc_stage_cfg.svh"

module enc_apb_regs
    import enc_stage_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`ENC_APB_AW-1:0] paddr,
    input  logic [`ENC_APB_DW-1:0] pwdata,
    output logic [`ENC_APB_DW-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output wgt_t [8:0]             kernel,
    output wgt_t                   bias,
    output logic                   img_we,
    output img_addr_t              img_waddr,
    output pix_t                   img_wdata,
    output pool_addr_t             pool_raddr,
    input  act_t                   pool_rdata,
    output logic                   conv_start,
    input  logic                   conv_done,
    output logic                   pool_start,
    input  logic                   pool_done
);
    localparam int IMG_WORDS = `ENC_IMG_W * `ENC_IMG_H;
    localparam int POOL_WORDS = `ENC_POOL_W * `ENC_POOL_H;

    logic                   access;
    logic                   aligned;
    logic                   sel_ctrl, sel_status, sel_kernel, sel_bias, sel_img, sel_pool;
    logic                   mapped;
    logic                   err;
    logic                   pool_rd;
    logic                   rd_wait;
    logic                   wr_en;
    logic                   start_req;
    logic [`ENC_APB_AW-1:0] koff;
    logic [3:0]             kidx;
    logic                   busy;
    logic                   done;

    function automatic logic [`ENC_APB_DW-1:0] sext(wgt_t w);
        return {{(`ENC_APB_DW-`ENC_WGT_W){w[`ENC_WGT_W-1]}}, w};
    endfunction

    // Address decode
    assign access = psel && penable;
    assign aligned = (paddr[1:0] == 2'b00);
    assign sel_ctrl = (paddr == `ENC_ADDR_CTRL);
    assign sel_status = (paddr == `ENC_ADDR_STATUS);
    assign sel_bias = (paddr == `ENC_ADDR_BIAS);
    assign sel_kernel = aligned && paddr >= `ENC_ADDR_KERNEL &&
                        paddr < `ENC_ADDR_KERNEL + `ENC_APB_AW'(4 * 9);
    assign sel_img = aligned && paddr >= `ENC_ADDR_IMAGE &&
                     paddr < `ENC_ADDR_IMAGE + `ENC_APB_AW'(4 * IMG_WORDS);
    assign sel_pool = aligned && paddr >= `ENC_ADDR_POOL &&
                      paddr < `ENC_ADDR_POOL + `ENC_APB_AW'(4 * POOL_WORDS);
    assign mapped = sel_ctrl || sel_status || sel_kernel || sel_bias || sel_img || sel_pool;

    assign koff = paddr - `ENC_ADDR_KERNEL;
    assign kidx = koff[5:2];

    // Error cases: unmapped, wrong direction, or weights/image/ctrl touched while busy
    assign err = !mapped ||
                 (pwrite && (sel_status || sel_pool)) ||
                 (!pwrite && sel_img) ||
                 (pwrite && busy && (sel_ctrl || sel_kernel || sel_bias || sel_img));

    assign pool_rd = !pwrite && sel_pool;
    assign pready = access && (!pool_rd || rd_wait);
    assign pslverr = pready && err;
    assign wr_en = pready && pwrite && !err;
    assign start_req = wr_en && sel_ctrl && pwdata[0];

    assign img_we = wr_en && sel_img;
    assign img_waddr = paddr[2 +: $bits(img_addr_t)];
    assign img_wdata = pwdata[`ENC_PIX_W-1:0];
    assign pool_raddr = paddr[2 +: $bits(pool_addr_t)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_wait <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            kernel <= '0;
            bias <= '0;
        end else begin
            rd_wait <= access && pool_rd && !rd_wait;
            conv_start <= start_req;
            // Convolution hands straight over to pooling
            pool_start <= conv_done;
            if (start_req) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (pool_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (wr_en && sel_kernel) begin
                kernel[kidx] <= pwdata[`ENC_WGT_W-1:0];
            end
            if (wr_en && sel_bias) begin
                bias <= pwdata[`ENC_WGT_W-1:0];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (sel_status) begin
            prdata = `ENC_APB_DW'({done, busy});
        end else if (sel_kernel) begin
            prdata = sext(kernel[kidx]);
        end else if (sel_bias) begin
            prdata = sext(bias);
        end else if (sel_pool) begin
            prdata = `ENC_APB_DW'(pool_rdata);
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

    // Pooling only finishes inside a run started over APB
    a_pool_done_busy: assert property (@(posedge clk) disable iff (rst) pool_done |-> busy);

endmodule

// File: logic/conv3x3_relu.sv
/* Zero-padded 3x3 convolution with bias and ReLU, 10 cycles per pixel
   Sum wraps to 16 bits before ReLU; image read latency must be one cycle */
`timescale 1ns/100ps
`include "enc_stage_cfg.svh"

module conv3x3_relu
    import enc_stage_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  wgt_t [8:0] kernel,
    input  wgt_t       bias,
    input  pix_t       img_rdata,
    output img_addr_t  img_raddr,
    output logic       act_we,
    output img_addr_t  act_waddr,
    output act_t       act_wdata,
    output logic       done
);
    localparam int RW = $clog2(`ENC_IMG_H);
    localparam int CW = $clog2(`ENC_IMG_W);

    logic          running;
    logic [RW-1:0] row;
    logic [CW-1:0] col;
    logic [3:0]    tap;
    logic [1:0]    ky;
    logic [1:0]    kx;
    logic [RW:0]   in_r;
    logic [CW:0]   in_c;
    logic          in_frame;
    logic          last_tap;
    logic          tap_valid_q;
    wgt_t          tap_wgt_q;
    acc_t          acc;
    acc_t          prod;
    acc_t          sum;

    // Neighbour coordinates, top bit set means outside the frame
    assign in_r = (RW+1)'(row) + (RW+1)'(ky) - (RW+1)'(1);
    assign in_c = (CW+1)'(col) + (CW+1)'(kx) - (CW+1)'(1);
    assign in_frame = !in_r[RW] && !in_c[CW];
    assign img_raddr = {in_r[RW-1:0], in_c[CW-1:0]};

    assign last_tap = (tap == 4'd9);
    assign prod = acc_t'(img_rdata) * acc_t'(tap_wgt_q);
    assign sum = acc + (tap_valid_q ? prod : '0);

    assign act_we = running && last_tap;
    assign act_waddr = {row, col};
    assign act_wdata = sum[`ENC_PIX_W-1] ? '0 : sum[`ENC_PIX_W-2:0];
    assign done = act_we && row == RW'(`ENC_IMG_H-1) && col == CW'(`ENC_IMG_W-1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            row <= '0;
            col <= '0;
            tap <= '0;
            ky <= '0;
            kx <= '0;
        end else if (start) begin
            running <= 1'b1;
            row <= '0;
            col <= '0;
            tap <= '0;
            ky <= '0;
            kx <= '0;
        end else if (running) begin
            if (last_tap) begin
                tap <= '0;
                col <= col + 1'b1;
                if (col == CW'(`ENC_IMG_W-1)) begin
                    row <= row + 1'b1;
                    if (row == RW'(`ENC_IMG_H-1)) begin
                        running <= 1'b0;
                    end
                end
            end else begin
                tap <= tap + 1'b1;
                if (kx == 2'd2) begin
                    kx <= '0;
                    ky <= (ky == 2'd2) ? 2'd0 : ky + 1'b1;
                end else begin
                    kx <= kx + 1'b1;
                end
            end
        end
    end

    // Tap weight and mask line up with the read data one cycle later
    always_ff @(posedge clk) begin
        tap_valid_q <= in_frame;
        if (!last_tap) begin
            tap_wgt_q <= kernel[tap];
        end
        acc <= (tap == 4'd0) ? acc_t'(bias) : sum;
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !running);

endmodule

// File: logic/max_pool2x2.sv
/* 2x2 max pooling over the activation frame, 5 cycles per output
   Activation read latency must be one cycle */
`timescale 1ns/100ps
`include "enc_stage_cfg.svh"

module max_pool2x2
    import enc_stage_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  act_t       act_rdata,
    output img_addr_t  act_raddr,
    output logic       pool_we,
    output pool_addr_t pool_waddr,
    output act_t       pool_wdata,
    output logic       done
);
    localparam int PYW = $clog2(`ENC_POOL_H);
    localparam int PXW = $clog2(`ENC_POOL_W);

    logic           running;
    logic [PYW-1:0] py;
    logic [PXW-1:0] px;
    logic [2:0]     phase;
    act_t           max_q;
    act_t           max_d;

    // Window row and column come from the low phase bits
    assign act_raddr = {py, phase[1], px, phase[0]};
    assign max_d = (act_rdata > max_q) ? act_rdata : max_q;

    assign pool_we = running && phase == 3'd4;
    assign pool_waddr = {py, px};
    assign pool_wdata = max_d;
    assign done = pool_we && py == PYW'(`ENC_POOL_H-1) && px == PXW'(`ENC_POOL_W-1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            py <= '0;
            px <= '0;
            phase <= '0;
        end else if (start) begin
            running <= 1'b1;
            py <= '0;
            px <= '0;
            phase <= '0;
        end else if (running) begin
            if (phase == 3'd4) begin
                phase <= '0;
                px <= px + 1'b1;
                if (px == PXW'(`ENC_POOL_W-1)) begin
                    py <= py + 1'b1;
                    if (py == PYW'(`ENC_POOL_H-1)) begin
                        running <= 1'b0;
                    end
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Running max restarts from zero at each window
    always_ff @(posedge clk) begin
        max_q <= (phase == 3'd0) ? '0 : max_d;
    end

    a_we_in_run: assert property (@(posedge clk) disable iff (rst)
        pool_we |-> running && !start);

endmodule

// File: logic/enc_stage_top.sv
/* Encoder stage: APB registers, image memory, conv/ReLU, pooling, result memory
   All data and control pass over APB */
`timescale 1ns/100ps
`include "enc_stage_cfg.svh"

module enc_stage_top
    import enc_stage_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`ENC_APB_AW-1:0] paddr,
    input  logic [`ENC_APB_DW-1:0] pwdata,
    output logic [`ENC_APB_DW-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);
    wgt_t [8:0] kernel;
    wgt_t       bias;
    logic       img_we;
    img_addr_t  img_waddr;
    pix_t       img_wdata;
    img_addr_t  img_raddr;
    pix_t       img_rdata;
    logic       act_we;
    img_addr_t  act_waddr;
    act_t       act_wdata;
    img_addr_t  act_raddr;
    act_t       act_rdata;
    logic       pool_we;
    pool_addr_t pool_waddr;
    act_t       pool_wdata;
    pool_addr_t pool_raddr;
    act_t       pool_rdata;
    logic       conv_start, conv_done;
    logic       pool_start, pool_done;

    enc_apb_regs apb_regs_i (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .kernel, .bias, .img_we, .img_waddr, .img_wdata, .pool_raddr, .pool_rdata,
        .conv_start, .conv_done, .pool_start, .pool_done
    );

    pixel_ram #(.T(pix_t), .DEPTH(`ENC_IMG_W * `ENC_IMG_H)) image_ram (
        .clk, .we(img_we), .waddr(img_waddr), .wdata(img_wdata),
        .raddr(img_raddr), .rdata(img_rdata)
    );

    conv3x3_relu conv_i (
        .clk, .rst, .start(conv_start), .kernel, .bias, .img_rdata, .img_raddr,
        .act_we, .act_waddr, .act_wdata, .done(conv_done)
    );

    pixel_ram #(.T(act_t), .DEPTH(`ENC_IMG_W * `ENC_IMG_H)) conv_ram (
        .clk, .we(act_we), .waddr(act_waddr), .wdata(act_wdata),
        .raddr(act_raddr), .rdata(act_rdata)
    );

    max_pool2x2 pool_i (
        .clk, .rst, .start(pool_start), .act_rdata, .act_raddr,
        .pool_we, .pool_waddr, .pool_wdata, .done(pool_done)
    );

    pixel_ram #(.T(act_t), .DEPTH(`ENC_POOL_W * `ENC_POOL_H)) pool_ram (
        .clk, .we(pool_we), .waddr(pool_waddr), .wdata(pool_wdata),
        .raddr(pool_raddr), .rdata(pool_rdata)
    );

endmodule

// File: tb/enc_stage_tb.sv
/* Testbench for the encoder stage; every access goes over APB
   Expected pool words come from a behavioural model of padding, bias, wrap, ReLU and pooling */
`timescale 1ns/100ps
`include "enc_stage_cfg.svh"

module enc_stage_tb
    import enc_stage_pkg::*;
();
    localparam int RUN_CYCLES = 4000;
    localparam int NUM_RUNS = 3;
    localparam int LIMIT = NUM_RUNS * RUN_CYCLES + 2000;
    localparam int IMG_WORDS = `ENC_IMG_W * `ENC_IMG_H;
    localparam int POOL_WORDS = `ENC_POOL_W * `ENC_POOL_H;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic                   psel = 1'b0;
    logic                   penable = 1'b0;
    logic                   pwrite = 1'b0;
    logic [`ENC_APB_AW-1:0] paddr = '0;
    logic [`ENC_APB_DW-1:0] pwdata = '0;
    logic [`ENC_APB_DW-1:0] prdata;
    logic                   pready;
    logic                   pslverr;

    logic [31:0] lfsr_state = 32'd67264;
    pix_t        img [IMG_WORDS];
    wgt_t        kern [9];
    wgt_t        bias_v;
    act_t        exp_pool [POOL_WORDS];

    enc_stage_top enc_stage_top_i (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        abort_run();
    endtask

    a_resp_in_access: assert property (@(posedge clk) disable iff (rst)
        (pready || pslverr) |-> (psel && penable))
        else report_failure("pready or pslverr was high outside an APB access phase");

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    task automatic apb_access(input logic wr, input logic [`ENC_APB_AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        // Pool reads hold pready low for one wait state
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [`ENC_APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        assert (err == exp_err)
            else report_mismatch($sformatf("pslverr, write 0x%h", addr), 32'(exp_err), 32'(err));
    endtask

    task automatic read_reg(input logic [`ENC_APB_AW-1:0] addr, input logic exp_err,
                            output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        assert (err == exp_err)
            else report_mismatch($sformatf("pslverr, read 0x%h", addr), 32'(exp_err), 32'(err));
    endtask

    task automatic check_read(input string name, input logic [`ENC_APB_AW-1:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        read_reg(addr, 1'b0, rd);
        assert (rd == exp) else report_mismatch(name, exp, rd);
    endtask

    task automatic check_weights();
        for (int t = 0; t < 9; t++) begin
            check_read($sformatf("kernel[%0d]", t), `ENC_ADDR_KERNEL + 12'(4 * t),
                       32'(int'(kern[t])));
        end
        check_read("bias", `ENC_ADDR_BIAS, 32'(int'(bias_v)));
    endtask

    task automatic load_frame();
        for (int t = 0; t < 9; t++) begin
            write_reg(`ENC_ADDR_KERNEL + 12'(4 * t), 32'(int'(kern[t])), 1'b0);
        end
        write_reg(`ENC_ADDR_BIAS, 32'(int'(bias_v)), 1'b0);
        check_weights();
        for (int i = 0; i < IMG_WORDS; i++) begin
            write_reg(`ENC_ADDR_IMAGE + 12'(4 * i), {16'h0, img[i]}, 1'b0);
        end
    endtask

    task automatic randomize_frame();
        for (int t = 0; t < 9; t++) begin
            kern[t] = wgt_t'(rand_bits(8));
        end
        bias_v = wgt_t'(rand_bits(8));
        for (int i = 0; i < IMG_WORDS; i++) begin
            img[i] = pix_t'(rand_bits(16));
        end
    endtask

    task automatic compute_model();
        int          sum;
        int          rr;
        int          cc;
        int          idx;
        logic [15:0] low;
        act_t        best;
        act_t        act [IMG_WORDS];
        for (int r = 0; r < `ENC_IMG_H; r++) begin
            for (int c = 0; c < `ENC_IMG_W; c++) begin
                sum = int'(bias_v);
                for (int t = 0; t < 9; t++) begin
                    rr = r + t / 3 - 1;
                    cc = c + t % 3 - 1;
                    // Padding taps add nothing
                    if (rr >= 0 && rr < `ENC_IMG_H && cc >= 0 && cc < `ENC_IMG_W) begin
                        sum += int'(img[rr * `ENC_IMG_W + cc]) * int'(kern[t]);
                    end
                end
                low = sum[15:0];
                act[r * `ENC_IMG_W + c] = low[15] ? '0 : low[14:0];
            end
        end
        for (int py = 0; py < `ENC_POOL_H; py++) begin
            for (int px = 0; px < `ENC_POOL_W; px++) begin
                best = '0;
                for (int w = 0; w < 4; w++) begin
                    idx = (2 * py + w / 2) * `ENC_IMG_W + 2 * px + w % 2;
                    if (act[idx] > best) begin
                        best = act[idx];
                    end
                end
                exp_pool[py * `ENC_POOL_W + px] = best;
            end
        end
    endtask

    // Single centre tap: pool word is the largest non-negative pixel of the window
    task automatic centre_tap_model();
        int   idx;
        act_t best;
        for (int py = 0; py < `ENC_POOL_H; py++) begin
            for (int px = 0; px < `ENC_POOL_W; px++) begin
                best = '0;
                for (int w = 0; w < 4; w++) begin
                    idx = (2 * py + w / 2) * `ENC_IMG_W + 2 * px + w % 2;
                    if (int'(img[idx]) > int'(best)) begin
                        best = img[idx][14:0];
                    end
                end
                exp_pool[py * `ENC_POOL_W + px] = best;
            end
        end
    endtask

    task automatic check_bad_access();
        logic [31:0] rd;
        read_reg(12'h100, 1'b1, rd);
        write_reg(12'h100, 32'h1, 1'b1);
        read_reg(`ENC_ADDR_IMAGE + 12'h10, 1'b1, rd);
        write_reg(`ENC_ADDR_STATUS, 32'h3, 1'b1);
        write_reg(`ENC_ADDR_POOL, 32'h1, 1'b1);
    endtask

    task automatic reject_while_busy();
        write_reg(`ENC_ADDR_KERNEL, 32'(int'(~kern[0])), 1'b1);
        write_reg(`ENC_ADDR_KERNEL + 12'd16, 32'h0000_007f, 1'b1);
        write_reg(`ENC_ADDR_BIAS, 32'(int'(~bias_v)), 1'b1);
        write_reg(`ENC_ADDR_IMAGE + 12'h20, 32'h0000_1234, 1'b1);
        write_reg(`ENC_ADDR_CTRL, 32'h1, 1'b1);
        check_weights();
    endtask

    task automatic run_frame(input logic busy_checks);
        logic [31:0] st;
        write_reg(`ENC_ADDR_CTRL, 32'h1, 1'b0);
        // Start clears done and sets busy
        check_read("status", `ENC_ADDR_STATUS, 32'h1);
        if (busy_checks) begin
            reject_while_busy();
        end
        read_reg(`ENC_ADDR_STATUS, 1'b0, st);
        while (!st[1]) begin
            assert (st == 32'h1) else report_mismatch("status", 32'h1, st);
            read_reg(`ENC_ADDR_STATUS, 1'b0, st);
        end
        assert (st == 32'h2) else report_mismatch("status", 32'h2, st);
        for (int i = 0; i < POOL_WORDS; i++) begin
            check_read($sformatf("pool[%0d]", i), `ENC_ADDR_POOL + 12'(4 * i),
                       32'(exp_pool[i]));
        end
    endtask

    initial begin
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        check_read("status", `ENC_ADDR_STATUS, 32'h0);
        for (int t = 0; t < 9; t++) begin
            kern[t] = '0;
        end
        bias_v = '0;
        check_weights();
        check_bad_access();

        randomize_frame();
        load_frame();
        compute_model();
        run_frame(1'b1);
        // done holds until the next start
        repeat (50) @(posedge clk);
        check_read("status", `ENC_ADDR_STATUS, 32'h2);

        randomize_frame();
        for (int t = 0; t < 9; t++) begin
            kern[t] = (t == 4) ? wgt_t'(1) : wgt_t'(0);
        end
        bias_v = '0;
        // First window all negative
        img[0][15] = 1'b1;
        img[1][15] = 1'b1;
        img[8][15] = 1'b1;
        img[9][15] = 1'b1;
        load_frame();
        centre_tap_model();
        run_frame(1'b0);

        randomize_frame();
        load_frame();
        compute_model();
        run_frame(1'b0);

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        report_failure($sformatf("Timeout: simulation did not finish within %0d cycles", LIMIT));
    end

endmodule

// File: enc_stage_top.f
+incdir+include
logic/enc_stage_pkg.sv
logic/pixel_ram.sv
logic/enc_apb_regs.sv
logic/conv3x3_relu.sv
logic/max_pool2x2.sv
logic/enc_stage_top.sv
tb/enc_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the encoder stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module enc_stage_tb -f enc_stage_top.f \
    -o enc_stage_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/enc_stage_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
